// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j $(JOBS)
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
logic/mips_isa_pkg.sv
logic/ex_pipe_pkg.sv
logic/ex_alu.sv
logic/ex_muldiv.sv
logic/ex_stage.sv
dv/ex_stage_tb.sv

// File: dv/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

    localparam int clk_half   = 2;
    localparam int drive_dly  = 1;
    localparam int rec_w      = 14;
    localparam int addr_w     = 10;
    localparam int mem_words  = 1 << addr_w;
    localparam int max_rec    = mem_words / rec_w;
    localparam int wait_max   = 64;
    localparam int md_latency = mips_isa_pkg::DATA_W + 1;

    // one line of the data file, one 32-bit word per column
    typedef struct packed {
        logic [31:0] group;
        logic [31:0] mode;
        logic [31:0] op_class;
        logic [31:0] alu_op;
        logic [31:0] dest;
        logic [31:0] opa;
        logic [31:0] opb;
        logic [31:0] gpr_we;
        logic [31:0] gpr_data;
        logic [31:0] hi_we;
        logic [31:0] lo_we;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] ovf;
    } stim_rec_t;

    logic                    clk;
    logic                    reset;
    logic                    flush;
    ex_pipe_pkg::ex_instr_t  instr;
    logic                    stall;
    ex_pipe_pkg::ex_result_t result;

    logic [31:0] stim_mem [0:mem_words-1];
    int          errors;
    int          checks;
    int          cur_rec;
    logic [31:0] cur_group;
    logic        timed_out;

    ex_stage i_dut (
        .clk_i    (clk),
        .reset_i  (reset),
        .flush_i  (flush),
        .instr_i  (instr),
        .stall_o  (stall),
        .result_o (result)
    );

    always #clk_half clk = ~clk;

    ////////////////////////////////////////
    // data file access
    ////////////////////////////////////////
    function automatic logic [31:0] word_at(input int idx);
        return stim_mem[addr_w'(idx)];
    endfunction

    // unwritten words carry their own address
    function automatic logic [31:0] fill_word(input int idx);
        return 32'hffff_0000 | 32'(idx);
    endfunction

    function automatic stim_rec_t fetch_rec(input int idx);
        stim_rec_t rec;
        int        base;
        base         = idx * rec_w;
        rec.group    = word_at(base);
        rec.mode     = word_at(base + 1);
        rec.op_class = word_at(base + 2);
        rec.alu_op   = word_at(base + 3);
        rec.dest     = word_at(base + 4);
        rec.opa      = word_at(base + 5);
        rec.opb      = word_at(base + 6);
        rec.gpr_we   = word_at(base + 7);
        rec.gpr_data = word_at(base + 8);
        rec.hi_we    = word_at(base + 9);
        rec.lo_we    = word_at(base + 10);
        rec.hi       = word_at(base + 11);
        rec.lo       = word_at(base + 12);
        rec.ovf      = word_at(base + 13);
        return rec;
    endfunction

    function automatic string group_name(input logic [31:0] idx);
        case (idx)
            32'd0:   return "reset";
            32'd1:   return "arith";
            32'd2:   return "logic_shift";
            32'd3:   return "reg_zero";
            32'd4:   return "mult";
            32'd5:   return "div";
            32'd6:   return "move_flush";
            default: return "unknown";
        endcase
    endfunction

    // gpr data is defined only for ops that target a general register
    function automatic logic gpr_data_defined(input stim_rec_t rec);
        return rec.op_class[2:0] inside {mips_isa_pkg::op_arith, mips_isa_pkg::op_logic,
                                         mips_isa_pkg::op_shift} ||
               (rec.op_class[2:0] == mips_isa_pkg::op_muldiv &&
                rec.alu_op[4:0] == mips_isa_pkg::alu_mul);
    endfunction

    ////////////////////////////////////////
    // checks and bounded waits
    ////////////////////////////////////////
    task automatic check_val(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Mismatch %s #%0d %s: expected %h, actual %h",
                     group_name(cur_group), cur_rec, field, exp, act);
        end
    endtask

    task automatic wait_stall_low(output int cycles);
        int n;
        n = 0;
        while (stall && n < wait_max) begin
            @(posedge clk);
            #drive_dly;
            n++;
        end
        cycles = n;
        if (stall) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: stall_o still high after %0d cycles in %s #%0d",
                     wait_max, group_name(cur_group), cur_rec);
        end
    endtask

    task automatic wait_result(output int cycles);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #drive_dly;
            n++;
        end while (!result.valid && n < wait_max);
        cycles = n;
        if (!result.valid) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: no valid result within %0d cycles in %s #%0d",
                     wait_max, group_name(cur_group), cur_rec);
        end
    endtask

    task automatic check_result(input stim_rec_t rec);
        check_val("gpr_we", rec.gpr_we, 32'(result.gpr_we));
        check_val("gpr_addr", rec.dest, 32'(result.gpr_addr));
        check_val("hi_we", rec.hi_we, 32'(result.hi_we));
        check_val("lo_we", rec.lo_we, 32'(result.lo_we));
        check_val("overflow", rec.ovf, 32'(result.overflow));
        if (gpr_data_defined(rec)) begin
            check_val("gpr_data", rec.gpr_data, result.gpr_data);
        end
        if (rec.hi_we[0]) begin
            check_val("hi_data", rec.hi, result.hi_data);
        end
        if (rec.lo_we[0]) begin
            check_val("lo_data", rec.lo, result.lo_data);
        end
    endtask

    // abort a running divide, no result may follow
    task automatic run_flush();
        repeat (4) begin
            @(posedge clk);
            #drive_dly;
        end
        check_val("stall_o before flush", 32'd1, 32'(stall));
        flush = 1'b1;
        #drive_dly;
        check_val("stall_o on flush", 32'd0, 32'(stall));
        @(posedge clk);
        #drive_dly;
        flush       = 1'b0;
        instr.valid = 1'b0;
        repeat (4) begin
            check_val("valid after flush", 32'd0, 32'(result.valid));
            check_val("stall_o after flush", 32'd0, 32'(stall));
            @(posedge clk);
            #drive_dly;
        end
    endtask

    task automatic run_one(input stim_rec_t rec);
        logic is_md;
        int   n_stall;
        int   n_res;
        is_md          = rec.op_class[2:0] == mips_isa_pkg::op_muldiv;
        n_stall        = 0;
        n_res          = 0;
        instr.valid    = 1'b1;
        instr.op_class = mips_isa_pkg::op_class_e'(rec.op_class[2:0]);
        instr.alu_op   = mips_isa_pkg::alu_op_e'(rec.alu_op[4:0]);
        instr.dest     = rec.dest[mips_isa_pkg::REG_ADDR_W-1:0];
        instr.opa      = rec.opa;
        instr.opb      = rec.opb;
        #drive_dly;
        // muldiv stalls as soon as it is presented
        check_val("stall_o", {31'd0, is_md}, 32'(stall));
        if (rec.mode == 32'd1) begin
            run_flush();
        end else begin
            if (is_md) begin
                wait_stall_low(n_stall);
            end
            if (!timed_out) begin
                wait_result(n_res);
            end
            if (!timed_out) begin
                check_result(rec);
                // one cycle per bit plus the accepting edge for muldiv
                check_val("latency", is_md ? 32'(md_latency) : 32'd1,
                          32'(n_stall + n_res));
            end
            instr.valid = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int        n_rec;
        int        i;
        stim_rec_t rec;
        clk       = 1'b0;
        reset     = 1'b1;
        flush     = 1'b0;
        instr     = '0;
        errors    = 0;
        checks    = 0;
        cur_rec   = 0;
        cur_group = '0;
        timed_out = 1'b0;

        // a word still holding its fill marks the end of the records
        for (i = 0; i < mem_words; i++) begin
            stim_mem[addr_w'(i)] = fill_word(i);
        end
        $readmemh("dv/ex_stim.txt", stim_mem);
        n_rec = 0;
        while (n_rec < max_rec &&
               word_at(n_rec * rec_w) != fill_word(n_rec * rec_w)) begin
            n_rec++;
        end
        if (n_rec == 0) begin
            errors++;
            $display("no stimulus records were read from dv/ex_stim.txt");
        end

        repeat (3) @(posedge clk);
        #drive_dly;
        reset = 1'b0;
        check_val("valid", 32'd0, 32'(result.valid));
        check_val("gpr_we", 32'd0, 32'(result.gpr_we));
        check_val("hi_we", 32'd0, 32'(result.hi_we));
        check_val("lo_we", 32'd0, 32'(result.lo_we));
        check_val("stall_o", 32'd0, 32'(stall));

        for (i = 0; i < n_rec && !timed_out; i++) begin
            rec       = fetch_rec(i);
            cur_rec   = i;
            cur_group = rec.group;
            run_one(rec);
        end

        repeat (2) @(posedge clk);
        $display("records: %0d, checks: %0d, errors: %0d", n_rec, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/ex_stim.txt
// group mode class op dest opa opb gpr_we gpr_data hi_we lo_we hi lo ovf
// group 1 arith 2 logic_shift 3 reg_zero 4 mult 5 div 6 move_flush, mode 1 flushes mid-run
1 0 0 00 03 00000005 00000007 1 0000000c 0 0 00000000 00000000 0
1 0 0 00 04 7fffffff 00000001 0 80000000 0 0 00000000 00000000 1
1 0 0 02 05 80000000 00000001 0 7fffffff 0 0 00000000 00000000 1
1 0 0 02 06 00000000 80000000 0 80000000 0 0 00000000 00000000 1
1 0 0 02 0d 00000010 00000003 1 0000000d 0 0 00000000 00000000 0
1 0 0 01 07 ffffffff 00000002 1 00000001 0 0 00000000 00000000 0
1 0 0 03 08 00000000 00000001 1 ffffffff 0 0 00000000 00000000 0
1 0 0 04 09 ffffffff 00000001 1 00000001 0 0 00000000 00000000 0
1 0 0 04 0a 00000005 fffffffb 1 00000000 0 0 00000000 00000000 0
1 0 0 05 0b ffffffff 00000001 1 00000000 0 0 00000000 00000000 0
1 0 0 05 0c 00000001 ffffffff 1 00000001 0 0 00000000 00000000 0
2 0 1 06 10 f0f0ff00 0ff0f0f0 1 00f0f000 0 0 00000000 00000000 0
2 0 1 07 11 f0f0ff00 0ff0f0f0 1 fff0fff0 0 0 00000000 00000000 0
2 0 1 08 12 f0f0ff00 0ff0f0f0 1 000f000f 0 0 00000000 00000000 0
2 0 1 09 13 f0f0ff00 0ff0f0f0 1 ff000ff0 0 0 00000000 00000000 0
2 0 2 0a 14 00000004 00000f0f 1 0000f0f0 0 0 00000000 00000000 0
2 0 2 0b 15 00000008 80000000 1 00800000 0 0 00000000 00000000 0
2 0 2 0c 16 00000008 80000000 1 ff800000 0 0 00000000 00000000 0
2 0 2 0a 18 00000021 00000001 1 00000002 0 0 00000000 00000000 0
3 0 0 00 00 00000005 00000007 0 0000000c 0 0 00000000 00000000 0
3 0 1 07 00 00000001 00000002 0 00000003 0 0 00000000 00000000 0
3 0 4 0f 00 00000003 00000004 0 0000000c 0 0 00000000 00000000 0
4 0 4 0d 02 00000003 fffffffe 0 00000000 1 1 ffffffff fffffffa 0
4 0 4 0e 02 ffffffff ffffffff 0 00000000 1 1 fffffffe 00000001 0
4 0 4 0d 02 80000000 80000000 0 00000000 1 1 40000000 00000000 0
4 0 4 0f 03 00000007 fffffff9 1 ffffffcf 0 0 00000000 00000000 0
5 0 4 10 02 00000064 00000007 0 00000000 1 1 00000002 0000000e 0
5 0 4 10 02 ffffff9c 00000007 0 00000000 1 1 fffffffe fffffff2 0
5 0 4 10 02 00000064 fffffff9 0 00000000 1 1 00000002 fffffff2 0
5 0 4 10 02 ffffff9c fffffff9 0 00000000 1 1 fffffffe 0000000e 0
5 0 4 11 02 ffffffff 00000010 0 00000000 1 1 0000000f 0fffffff 0
5 0 4 11 02 00000005 00000000 0 00000000 1 1 00000005 ffffffff 0
6 0 3 12 00 deadbeef 00000000 0 00000000 1 0 deadbeef 00000000 0
6 0 3 13 00 12345678 00000000 0 00000000 0 1 00000000 12345678 0
6 1 4 10 02 00000064 00000007 0 00000000 0 0 00000000 00000000 0
6 0 4 10 02 00000064 00000007 0 00000000 1 1 00000002 0000000e 0
6 0 0 00 01 00000001 00000001 1 00000002 0 0 00000000 00000000 0

// File: logic/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu #(
    parameter int data_w = mips_isa_pkg::DATA_W
) (
    input  mips_isa_pkg::alu_op_e alu_op_i,
    input  logic [data_w-1:0]     opa_i,
    input  logic [data_w-1:0]     opb_i,
    output logic [data_w-1:0]     result_o,
    output logic                  overflow_o
);

    localparam int sh_w = $clog2(data_w);
    localparam int msb  = data_w - 1;

    logic              is_sub;
    logic [data_w-1:0] opb_add;
    logic [data_w-1:0] sum;
    logic              ovf_raw;
    logic              lt_signed;
    logic              lt_unsigned;
    logic [sh_w-1:0]   shamt;
    logic [data_w:0]   wide_sum;

    ////////////////////////////////////////
    // adder, shared by add/sub/slt
    ////////////////////////////////////////
    assign is_sub  = alu_op_i inside {mips_isa_pkg::alu_sub, mips_isa_pkg::alu_subu,
                                      mips_isa_pkg::alu_slt};
    assign opb_add = is_sub ? (~opb_i) + data_w'(1) : opb_i;
    assign sum     = opa_i + opb_add;

    // compare against the raw opb sign so that sub of the most negative value is caught
    assign ovf_raw = is_sub ? (opa_i[msb] != opb_i[msb]) && (sum[msb] != opa_i[msb])
                            : (opa_i[msb] == opb_i[msb]) && (sum[msb] != opa_i[msb]);

    assign overflow_o = ovf_raw && (alu_op_i inside {mips_isa_pkg::alu_add,
                                                     mips_isa_pkg::alu_sub});

    // signed less-than from the difference
    assign lt_signed   = (opa_i[msb] & ~opb_i[msb]) |
                         (~(opa_i[msb] ^ opb_i[msb]) & sum[msb]);
    assign lt_unsigned = opa_i < opb_i;

    assign shamt = opa_i[sh_w-1:0];

    // sign-extended by one bit, so the true result always fits
    assign wide_sum = is_sub ? {opa_i[msb], opa_i} - {opb_i[msb], opb_i}
                             : {opa_i[msb], opa_i} + {opb_i[msb], opb_i};

    ////////////////////////////////////////
    // result mux
    ////////////////////////////////////////
    always_comb begin
        result_o = '0;
        unique case (alu_op_i)
            mips_isa_pkg::alu_add,
            mips_isa_pkg::alu_addu,
            mips_isa_pkg::alu_sub,
            mips_isa_pkg::alu_subu: result_o = sum;
            mips_isa_pkg::alu_slt:  result_o = {{(data_w-1){1'b0}}, lt_signed};
            mips_isa_pkg::alu_sltu: result_o = {{(data_w-1){1'b0}}, lt_unsigned};
            mips_isa_pkg::alu_and:  result_o = opa_i & opb_i;
            mips_isa_pkg::alu_or:   result_o = opa_i | opb_i;
            mips_isa_pkg::alu_nor:  result_o = ~(opa_i | opb_i);
            mips_isa_pkg::alu_xor:  result_o = opa_i ^ opb_i;
            mips_isa_pkg::alu_sll:  result_o = opb_i << shamt;
            mips_isa_pkg::alu_srl:  result_o = opb_i >> shamt;
            // arithmetic shift keeps the sign of rt
            mips_isa_pkg::alu_sra:  result_o = $signed(opb_i) >>> shamt;
            default:                result_o = '0;
        endcase
    end

    // only add/sub trap, and only when the widened result leaves the signed range
    always_comb begin
        assert (overflow_o == ((alu_op_i inside {mips_isa_pkg::alu_add,
                                                 mips_isa_pkg::alu_sub}) &&
                               (wide_sum[data_w] != wide_sum[msb])))
            else $error("overflow_o disagrees with the widened result for %s",
                        alu_op_i.name());
    end

endmodule

`default_nettype wire

// File: logic/ex_muldiv.sv
`timescale 1ns/1ps
`default_nettype none

module ex_muldiv #(
    parameter int data_w = mips_isa_pkg::DATA_W
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  start_i,
    input  logic                  abort_i,
    input  mips_isa_pkg::alu_op_e alu_op_i,
    input  logic [data_w-1:0]     opa_i,
    input  logic [data_w-1:0]     opb_i,
    output logic                  done_o,
    output logic [data_w-1:0]     hi_o,
    output logic [data_w-1:0]     lo_o
);

    localparam int cnt_w = $clog2(data_w);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } state_e;

    state_e              state_q;
    logic [cnt_w-1:0]    cnt_q;
    logic [2*data_w-1:0] acc_q;
    logic [2*data_w-1:0] acc_src;
    logic [2*data_w-1:0] acc_step;
    logic                is_div;
    logic                is_signed;
    logic                a_neg;
    logic                b_neg;
    logic [data_w-1:0]   a_mag;
    logic [data_w-1:0]   b_mag;
    logic [data_w:0]     add_sum;
    logic [data_w:0]     shifted;
    logic [data_w:0]     diff;
    logic [2*data_w-1:0] prod_fix;
    logic [data_w-1:0]   quo_fix;
    logic [data_w-1:0]   rem_fix;

    ////////////////////////////////////////
    // operand prep
    ////////////////////////////////////////
    // inputs stay held upstream for the whole operation
    assign is_div    = alu_op_i inside {mips_isa_pkg::alu_div, mips_isa_pkg::alu_divu};
    assign is_signed = alu_op_i inside {mips_isa_pkg::alu_mult, mips_isa_pkg::alu_mul,
                                        mips_isa_pkg::alu_div};
    assign a_neg = is_signed & opa_i[data_w-1];
    assign b_neg = is_signed & opb_i[data_w-1];
    assign a_mag = a_neg ? -opa_i : opa_i;
    assign b_mag = b_neg ? -opb_i : opb_i;

    // first step is taken on the start edge
    assign acc_src = (state_q == st_idle) ? {{data_w{1'b0}}, a_mag} : acc_q;

    // shift-add: upper half accumulates, multiplier drains from the bottom
    assign add_sum = {1'b0, acc_src[2*data_w-1:data_w]} +
                     (acc_src[0] ? {1'b0, b_mag} : '0);

    // restoring: {rem, quotient msb} minus divisor
    assign shifted = acc_src[2*data_w-1:data_w-1];
    assign diff    = shifted - {1'b0, b_mag};

    always_comb begin
        if (!is_div) begin
            acc_step = {add_sum, acc_src[data_w-1:1]};
        end else if (diff[data_w]) begin
            acc_step = {shifted[data_w-1:0], acc_src[data_w-2:0], 1'b0};
        end else begin
            acc_step = {diff[data_w-1:0], acc_src[data_w-2:0], 1'b1};
        end
    end

    ////////////////////////////////////////
    // controller
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i || abort_i) begin
            state_q <= st_idle;
            cnt_q   <= '0;
        end else begin
            unique case (state_q)
                st_idle: begin
                    if (start_i) begin
                        state_q <= st_run;
                        cnt_q   <= cnt_w'(1);
                    end
                end
                st_run: begin
                    cnt_q <= cnt_q + cnt_w'(1);
                    if (cnt_q == cnt_w'(data_w - 1)) begin
                        state_q <= st_done;
                    end
                end
                st_done: state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == st_idle && start_i) || state_q == st_run) begin
            acc_q <= acc_step;
        end
    end

    assign done_o = (state_q == st_done);

    // sign fix; remainder follows the dividend
    assign prod_fix = (a_neg ^ b_neg) ? -acc_q : acc_q;
    assign quo_fix  = (a_neg ^ b_neg) ? -acc_q[data_w-1:0] : acc_q[data_w-1:0];
    assign rem_fix  = a_neg ? -acc_q[2*data_w-1:data_w] : acc_q[2*data_w-1:data_w];

    always_comb begin
        if (!is_div) begin
            {hi_o, lo_o} = prod_fix;
        end else if (opb_i == '0) begin
            lo_o = '1;
            hi_o = opa_i;
        end else begin
            lo_o = quo_fix;
            hi_o = rem_fix;
        end
    end

    // one step per bit, then done for a single cycle
    ap_done_latency: assert property (@(posedge clk_i) disable iff (reset_i || abort_i)
        state_q == st_idle && start_i |-> ##data_w done_o ##1 !done_o)
        else $error("done_o is not a single pulse data_w cycles after start");

    // the stage must track busy on its side
    ap_no_start_in_run: assert property (@(posedge clk_i) disable iff (reset_i)
        state_q == st_run |-> !start_i)
        else $error("start_i raised while the unit is running");

endmodule

`default_nettype wire

// File: logic/ex_pipe_pkg.sv
`default_nettype none

package ex_pipe_pkg;

    ////////////////////////////////////////
    // instruction entering execute
    ////////////////////////////////////////
    typedef struct packed {
        logic                                valid;
        mips_isa_pkg::op_class_e             op_class;
        mips_isa_pkg::alu_op_e               alu_op;
        // destination general register
        logic [mips_isa_pkg::REG_ADDR_W-1:0] dest;
        // rs / rt values after forwarding
        logic [mips_isa_pkg::DATA_W-1:0]     opa;
        logic [mips_isa_pkg::DATA_W-1:0]     opb;
    } ex_instr_t;

    ////////////////////////////////////////
    // result leaving execute
    ////////////////////////////////////////
    typedef struct packed {
        logic                                valid;
        // general register write
        logic                                gpr_we;
        logic [mips_isa_pkg::REG_ADDR_W-1:0] gpr_addr;
        logic [mips_isa_pkg::DATA_W-1:0]     gpr_data;
        // hi/lo writes
        logic                                hi_we;
        logic                                lo_we;
        logic [mips_isa_pkg::DATA_W-1:0]     hi_data;
        logic [mips_isa_pkg::DATA_W-1:0]     lo_data;
        // signed overflow on add/sub
        logic                                overflow;
    } ex_result_t;

endpackage

`default_nettype wire

// File: logic/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   flush_i,
    input  ex_pipe_pkg::ex_instr_t instr_i,
    output logic                   stall_o,
    output ex_pipe_pkg::ex_result_t result_o
);

    localparam int data_w = mips_isa_pkg::DATA_W;

    logic [data_w-1:0]       alu_res;
    logic                    alu_ovf;
    logic [data_w-1:0]       md_hi;
    logic [data_w-1:0]       md_lo;
    logic                    md_done;
    logic                    md_start;
    logic                    busy_q;
    logic                    is_muldiv;
    logic                    muldiv_req;
    logic                    accept;
    logic                    writes_gpr;
    logic                    writes_hi;
    logic                    writes_lo;
    logic [data_w-1:0]       gpr_data;
    ex_pipe_pkg::ex_result_t result_d;
    ex_pipe_pkg::ex_result_t result_q;

    ex_alu #(
        .data_w (data_w)
    ) i_alu (
        .alu_op_i   (instr_i.alu_op),
        .opa_i      (instr_i.opa),
        .opb_i      (instr_i.opb),
        .result_o   (alu_res),
        .overflow_o (alu_ovf)
    );

    ex_muldiv #(
        .data_w (data_w)
    ) i_muldiv (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .start_i  (md_start),
        .abort_i  (flush_i),
        .alu_op_i (instr_i.alu_op),
        .opa_i    (instr_i.opa),
        .opb_i    (instr_i.opb),
        .done_o   (md_done),
        .hi_o     (md_hi),
        .lo_o     (md_lo)
    );

    ////////////////////////////////////////
    // stall and handshake
    ////////////////////////////////////////
    assign is_muldiv  = instr_i.op_class == mips_isa_pkg::op_muldiv;
    assign muldiv_req = instr_i.valid && is_muldiv && !flush_i;
    assign md_start   = muldiv_req && !busy_q;
    assign stall_o    = muldiv_req && !md_done;
    assign accept     = instr_i.valid && !stall_o && !flush_i;

    // mirrors run/done of the unit
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            busy_q <= 1'b0;
        end else if (md_start) begin
            busy_q <= 1'b1;
        end else if (md_done) begin
            busy_q <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // write-enable decode
    ////////////////////////////////////////
    always_comb begin
        writes_gpr = 1'b0;
        writes_hi  = 1'b0;
        writes_lo  = 1'b0;
        gpr_data   = alu_res;
        unique case (instr_i.op_class)
            mips_isa_pkg::op_arith,
            mips_isa_pkg::op_logic,
            mips_isa_pkg::op_shift: writes_gpr = 1'b1;
            mips_isa_pkg::op_move: begin
                writes_hi = instr_i.alu_op == mips_isa_pkg::alu_mthi;
                writes_lo = instr_i.alu_op == mips_isa_pkg::alu_mtlo;
                gpr_data  = instr_i.opa;
            end
            mips_isa_pkg::op_muldiv: begin
                // mul goes to rd, the rest only to hi/lo
                writes_gpr = instr_i.alu_op == mips_isa_pkg::alu_mul;
                writes_hi  = !writes_gpr;
                writes_lo  = !writes_gpr;
                gpr_data   = md_lo;
            end
            default: writes_gpr = 1'b0;
        endcase
    end

    always_comb begin
        result_d.valid    = accept;
        result_d.gpr_we   = accept && writes_gpr && !alu_ovf &&
                            instr_i.dest != {mips_isa_pkg::REG_ADDR_W{1'b0}};
        result_d.gpr_addr = instr_i.dest;
        result_d.gpr_data = gpr_data;
        result_d.hi_we    = accept && writes_hi;
        result_d.lo_we    = accept && writes_lo;
        result_d.hi_data  = is_muldiv ? md_hi : instr_i.opa;
        result_d.lo_data  = is_muldiv ? md_lo : instr_i.opa;
        result_d.overflow = accept && alu_ovf;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            result_q.valid  <= 1'b0;
            result_q.gpr_we <= 1'b0;
            result_q.hi_we  <= 1'b0;
            result_q.lo_we  <= 1'b0;
        end else begin
            result_q <= result_d;
        end
    end

    assign result_o = result_q;

    // upstream honours the stall
    ap_hold_on_stall: assert property (@(posedge clk_i) disable iff (reset_i)
        stall_o |=> $stable(instr_i))
        else $error("instr_i changed while stall_o was high");

endmodule

`default_nettype wire

// File: logic/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // datapath and register file geometry
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    ////////////////////////////////////////
    // unit that executes the instruction
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        op_arith  = 3'd0,
        op_logic  = 3'd1,
        op_shift  = 3'd2,
        op_move   = 3'd3,
        op_muldiv = 3'd4
    } op_class_e;

    ////////////////////////////////////////
    // operation within the class
    ////////////////////////////////////////
    typedef enum logic [4:0] {
        alu_add   = 5'd0,
        alu_addu  = 5'd1,
        alu_sub   = 5'd2,
        alu_subu  = 5'd3,
        alu_slt   = 5'd4,
        alu_sltu  = 5'd5,
        alu_and   = 5'd6,
        alu_or    = 5'd7,
        alu_nor   = 5'd8,
        alu_xor   = 5'd9,
        // shifts take the amount from opa
        alu_sll   = 5'd10,
        alu_srl   = 5'd11,
        alu_sra   = 5'd12,
        // multi-cycle unit
        alu_mult  = 5'd13,
        alu_multu = 5'd14,
        alu_mul   = 5'd15,
        alu_div   = 5'd16,
        alu_divu  = 5'd17,
        // hi/lo moves carry opa
        alu_mthi  = 5'd18,
        alu_mtlo  = 5'd19
    } alu_op_e;

endpackage

`default_nettype wire
